/* opll_cfg.svh */
/*
 * OPLL sound subsystem configuration
 * channel count, phase width, port addresses and mixer gain
 */
`ifndef OPLL_CFG_SVH
`define OPLL_CFG_SVH

// ------------------------------
// tone generation
// ------------------------------
`define OPLL_CH_NUM     9           // melody channels per frame
`define OPLL_PHASE_W    18          // phase accumulator bits

// ------------------------------
// output mixing
// ------------------------------
`define OPLL_MIX_SHIFT  6           // frame sum gain, left shift

// ------------------------------
// MSX bus ports
// ------------------------------
`define OPLL_MEM_ADDR   16'h7FF4    // memory mapped addr/data pair
`define OPLL_IO_ADDR    8'h7C       // I/O addr/data pair
`define OPLL_IOEN_ADDR  16'h7FF6    // bit 0 enables the I/O pair

`endif

/* opll_pkg.sv */
/*
 * OPLL shared types
 * register data byte views and the channel index
 */
package opll_pkg;

	// ------------------------------
	// register data views
	// ------------------------------

	// regs 20h..28h
	typedef struct packed {
		logic [1:0] rsvd;       // unused bits
		logic       sus;        // sustain, stored only
		logic       key;        // key-on
		logic [2:0] block;      // octave
		logic       fnum_hi;    // fnum bit 8
	} opll_ctrl_t;

	// regs 30h..38h
	typedef struct packed {
		logic [3:0] inst;       // instrument, stored only
		logic [3:0] atten;      // volume attenuation, 0 = loudest
	} opll_patch_t;

	// one data byte, decoded by register group
	typedef union packed {
		opll_ctrl_t  ctrl;
		opll_patch_t patch;
	} opll_reg_data_u;

	// ------------------------------
	// channel index
	// ------------------------------
	typedef logic [3:0] opll_ch_t;  // 0..8 used

endpackage

/* opll_bus_decoder.sv */
/*
 * OPLL bus decoder
 * MSX memory writes to 7FF4h/7FF5h and I/O writes to 7Ch/7Dh,
 * I/O pair gated by the 7FF6h enable bit; address latch and data strobe
 */
`timescale 1ns/1ns
`include "opll_cfg.svh"

module opll_bus_decoder #(
	parameter BUILT_IN_MODE = 0             // 0: cartridge, 1: built in
) (
	input  logic        clk,
	input  logic        n_reset,
	input  logic        i_n_ioreq,
	input  logic        i_n_sltsl,
	input  logic        i_n_wr,
	input  logic [15:0] i_address,
	input  logic [7:0]  i_wdata,
	output logic        o_reg_we,
	output logic [5:0]  o_reg_addr,
	output logic [7:0]  o_reg_data
);
	localparam logic [15:0] MEM_ADDR  = `OPLL_MEM_ADDR;
	localparam logic [7:0]  IO_ADDR   = `OPLL_IO_ADDR;
	localparam logic [15:0] IOEN_ADDR = `OPLL_IOEN_ADDR;

	logic ff_io_en;         // I/O pair enabled
	logic ff_cs_d;          // chip select, last clock
	logic ff_addr_ok;       // latched address fits 6 bits
	logic ff_reg_we;
	logic [5:0] ff_reg_addr;
	logic [7:0] ff_reg_data;
	logic w_mem_cs;
	logic w_io_cs;
	logic w_cs;
	logic w_cs_rise;        // first clock of a write

	// ------------------------------
	// address decode
	// ------------------------------
	assign w_mem_cs  = !i_n_sltsl && !i_n_wr && (i_address[15:1] == MEM_ADDR[15:1]);
	assign w_io_cs   = !i_n_ioreq && !i_n_wr && ff_io_en
	                   && (i_address[7:1] == IO_ADDR[7:1]);    // upper byte ignored
	assign w_cs      = w_mem_cs | w_io_cs;
	assign w_cs_rise = w_cs & ~ff_cs_d;    // held write counts once

	// ------------------------------
	// I/O port enable
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_io_en <= BUILT_IN_MODE[0];
		end else if (!i_n_sltsl && !i_n_wr && (i_address == IOEN_ADDR)) begin
			ff_io_en <= i_wdata[0];    // write 7FF6h
		end
	end

	// ------------------------------
	// address latch, data strobe
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_cs_d     <= 1'b0;
			ff_reg_we   <= 1'b0;
			ff_reg_addr <= '0;
			ff_addr_ok  <= 1'b1;
		end else begin
			ff_cs_d   <= w_cs;
			ff_reg_we <= 1'b0;    // one clock pulse
			if (w_cs_rise && !i_address[0]) begin
				ff_reg_addr <= i_wdata[5:0];              // even port, address
				ff_addr_ok  <= (i_wdata[7:6] == 2'b00);   // 40h and up unused
			end else if (w_cs_rise && i_address[0]) begin
				ff_reg_we <= ff_addr_ok;                  // odd port, data
			end
		end
	end

	always_ff @(posedge clk) begin
		if (w_cs_rise && i_address[0]) begin
			ff_reg_data <= i_wdata;    // payload
		end
	end

	assign o_reg_we   = ff_reg_we;
	assign o_reg_addr = ff_reg_addr;
	assign o_reg_data = ff_reg_data;

	// a held or repeated chip select must never stretch the strobe
	a_we_single : assert property (@(posedge clk) disable iff (!n_reset)
		o_reg_we |=> !o_reg_we);

endmodule

/* opll_reg_file.sv */
/*
 * OPLL register file
 * fnum, block, key and volume per channel, written from the bus decoder,
 * read combinationally by channel index
 */
`timescale 1ns/1ns
`include "opll_cfg.svh"

module opll_reg_file (
	input  logic              clk,
	input  logic              n_reset,
	input  logic              i_reg_we,
	input  logic [5:0]        i_reg_addr,
	input  logic [7:0]        i_reg_data,
	input  opll_pkg::opll_ch_t i_rd_ch,
	output logic [8:0]        o_fnum,
	output logic [2:0]        o_block,
	output logic              o_key,
	output logic [3:0]        o_atten
);
	import opll_pkg::*;

	localparam int CH_NUM = `OPLL_CH_NUM;

	// ------------------------------
	// storage
	// ------------------------------
	logic [7:0]     ff_fnum_lo [CH_NUM];    // regs 10h..18h
	opll_reg_data_u ff_ctrl    [CH_NUM];    // regs 20h..28h
	opll_reg_data_u ff_patch   [CH_NUM];    // regs 30h..38h

	opll_reg_data_u w_data;
	opll_ch_t       w_ch;
	logic           w_ch_ok;

	assign w_data  = i_reg_data;            // viewed per group below
	assign w_ch    = i_reg_addr[3:0];       // channel offset
	assign w_ch_ok = (w_ch < CH_NUM);       // offsets 9..F unused

	// ------------------------------
	// write port
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			for (int i = 0; i < CH_NUM; i++) begin
				ff_fnum_lo[i] <= '0;
				ff_ctrl[i]    <= '0;
				ff_patch[i]   <= '0;
			end
		end else if (i_reg_we && w_ch_ok) begin
			case (i_reg_addr[5:4])
				2'b01:   ff_fnum_lo[w_ch] <= w_data;    // fnum low byte
				2'b10:   ff_ctrl[w_ch]    <= w_data;    // sus/key/block/fnum8
				2'b11:   ff_patch[w_ch]   <= w_data;    // inst/atten
				default: ;                              // 00h..0Fh not kept
			endcase
		end
	end

	// ------------------------------
	// read port, same cycle
	// ------------------------------
	assign o_fnum  = {ff_ctrl[i_rd_ch].ctrl.fnum_hi, ff_fnum_lo[i_rd_ch]};
	assign o_block = ff_ctrl[i_rd_ch].ctrl.block;
	assign o_key   = ff_ctrl[i_rd_ch].ctrl.key;
	assign o_atten = ff_patch[i_rd_ch].patch.atten;    // inst nibble unused for tone

	// tone generator sequencing must stay within the nine channels
	a_rd_ch_range : assert property (@(posedge clk) disable iff (!n_reset)
		i_rd_ch < CH_NUM);

endmodule

/* opll_tone_gen.sv */
/*
 * OPLL tone generator
 * time-multiplexed phase accumulator, one channel per enabled clock,
 * square-wave sample per channel
 */
`timescale 1ns/1ns
`include "opll_cfg.svh"

module opll_tone_gen (
	input  logic               clk,
	input  logic               n_reset,
	input  logic               i_mclk_pcen_n,
	input  logic [8:0]         i_fnum,
	input  logic [2:0]         i_block,
	input  logic               i_key,
	input  logic [3:0]         i_atten,
	output opll_pkg::opll_ch_t o_rd_ch,
	output logic               o_smp_valid,
	output opll_pkg::opll_ch_t o_smp_ch,
	output logic [11:0]        o_smp_val
);
	import opll_pkg::*;

	localparam int       CH_NUM  = `OPLL_CH_NUM;
	localparam int       PW      = `OPLL_PHASE_W;
	localparam opll_ch_t LAST_CH = opll_ch_t'(CH_NUM - 1);

	logic [PW-1:0] ff_phase [CH_NUM];   // one phase per channel
	opll_ch_t      ff_ch;               // channel being read
	logic          ff_smp_valid;
	opll_ch_t      ff_smp_ch;
	logic [11:0]   ff_smp_val;

	logic          w_en;
	logic [PW-1:0] w_inc;
	logic [PW-1:0] w_phase_nxt;
	logic [9:0]    w_amp;
	logic [11:0]   w_smp;

	assign w_en = !i_mclk_pcen_n;       // active low enable pulse

	// ------------------------------
	// phase step and sample
	// ------------------------------
	assign w_inc       = {{(PW-9){1'b0}}, i_fnum} << i_block;   // max 16 bits, no wrap
	assign w_phase_nxt = i_key ? (ff_phase[ff_ch] + w_inc) : '0; // key-off clears
	assign w_amp       = i_key ? {4'd15 - i_atten, 6'd0} : '0;  // (15-atten) << 6
	assign w_smp       = w_phase_nxt[PW-1] ? -{2'b00, w_amp}    // second half negative
	                                       :  {2'b00, w_amp};

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			for (int i = 0; i < CH_NUM; i++) begin
				ff_phase[i] <= '0;
			end
		end else if (w_en) begin
			ff_phase[ff_ch] <= w_phase_nxt;    // mod 2^PW by width
		end
	end

	// ------------------------------
	// channel sequencer
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_ch        <= '0;
			ff_smp_valid <= 1'b0;
		end else begin
			ff_smp_valid <= w_en;    // sample one clock behind
			if (w_en) begin
				ff_ch <= (ff_ch == LAST_CH) ? '0 : ff_ch + 4'd1;
			end
		end
	end

	// next channel read overlaps this output
	always_ff @(posedge clk) begin
		if (w_en) begin
			ff_smp_ch  <= ff_ch;
			ff_smp_val <= w_smp;
		end
	end

	assign o_rd_ch     = ff_ch;
	assign o_smp_valid = ff_smp_valid;
	assign o_smp_ch    = ff_smp_ch;
	assign o_smp_val   = ff_smp_val;

endmodule

/* opll_mixer.sv */
/*
 * OPLL mixer
 * sums a frame of nine samples, applies gain, saturates to 16 bits
 */
`timescale 1ns/1ns
`include "opll_cfg.svh"

module opll_mixer (
	input  logic               clk,
	input  logic               n_reset,
	input  logic               i_smp_valid,
	input  opll_pkg::opll_ch_t i_smp_ch,
	input  logic [11:0]        i_smp_val,
	output logic               o_sound_strb,
	output logic [15:0]        o_sound_out
);
	import opll_pkg::*;

	localparam int       ACC_W   = 16;                  // 9 x 960 fits
	localparam int       SHIFT   = `OPLL_MIX_SHIFT;
	localparam int       SUM_W   = ACC_W + SHIFT;
	localparam opll_ch_t LAST_CH = opll_ch_t'(`OPLL_CH_NUM - 1);
	localparam logic signed [SUM_W-1:0] SAT_MAX = 32767;
	localparam logic signed [SUM_W-1:0] SAT_MIN = -32768;

	logic signed [ACC_W-1:0] ff_acc;
	logic                    ff_strb;
	logic [15:0]             ff_out;
	opll_ch_t                ff_last_ch;    // previous sample channel

	logic signed [ACC_W-1:0] w_smp;
	logic signed [ACC_W-1:0] w_sum;
	logic signed [SUM_W-1:0] w_scaled;
	logic [15:0]             w_sat;

	// ------------------------------
	// frame sum, gain, clamp
	// ------------------------------
	assign w_smp    = {{(ACC_W-12){i_smp_val[11]}}, i_smp_val};  // sign extend
	assign w_sum    = (i_smp_ch == '0) ? w_smp : ff_acc + w_smp; // ch 0 restarts
	assign w_scaled = SUM_W'(w_sum) <<< SHIFT;
	assign w_sat    = (w_scaled > SAT_MAX) ? 16'h7FFF :
	                  (w_scaled < SAT_MIN) ? 16'h8000 : w_scaled[15:0];

	always_ff @(posedge clk) begin
		if (i_smp_valid) begin
			ff_acc <= w_sum;
		end
	end

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_strb    <= 1'b0;
			ff_out     <= '0;
			ff_last_ch <= LAST_CH;    // next expected is ch 0
		end else begin
			ff_strb <= i_smp_valid && (i_smp_ch == LAST_CH);
			if (i_smp_valid) begin
				ff_last_ch <= i_smp_ch;
			end
			if (i_smp_valid && (i_smp_ch == LAST_CH)) begin
				ff_out <= w_sat;    // frame done
			end
		end
	end

	assign o_sound_strb = ff_strb;
	assign o_sound_out  = ff_out;

	// samples must come 0,1,..,8 then wrap
	a_ch_order : assert property (@(posedge clk) disable iff (!n_reset)
		i_smp_valid |-> (i_smp_ch == ((ff_last_ch == LAST_CH) ? 4'd0 : ff_last_ch + 4'd1)));

endmodule

/* opll_top.sv */
/*
 * OPLL sound subsystem top
 * bus decoder, register file, tone generator and mixer
 */
`timescale 1ns/1ns

module opll_top #(
	parameter BUILT_IN_MODE = 0             // 0: cartridge, 1: built in
) (
	input  logic        clk,
	input  logic        n_reset,
	input  logic        i_mclk_pcen_n,
	input  logic        i_n_ioreq,
	input  logic        i_n_sltsl,
	input  logic        i_n_wr,
	input  logic [15:0] i_address,
	input  logic [7:0]  i_wdata,
	output logic        o_sound_strb,
	output logic [15:0] o_sound_out
);
	import opll_pkg::*;

	// ------------------------------
	// internal nets
	// ------------------------------
	logic        reg_we;
	logic [5:0]  reg_addr;
	logic [7:0]  reg_data;
	opll_ch_t    rd_ch;
	logic [8:0]  fnum;
	logic [2:0]  block;
	logic        key;
	logic [3:0]  atten;
	logic        smp_valid;
	opll_ch_t    smp_ch;
	logic [11:0] smp_val;

	opll_bus_decoder #(
		.BUILT_IN_MODE (BUILT_IN_MODE)
	) u_bus_decoder (
		.clk        (clk),
		.n_reset    (n_reset),
		.i_n_ioreq  (i_n_ioreq),
		.i_n_sltsl  (i_n_sltsl),
		.i_n_wr     (i_n_wr),
		.i_address  (i_address),
		.i_wdata    (i_wdata),
		.o_reg_we   (reg_we),
		.o_reg_addr (reg_addr),
		.o_reg_data (reg_data)
	);

	opll_reg_file u_reg_file (
		.clk        (clk),
		.n_reset    (n_reset),
		.i_reg_we   (reg_we),
		.i_reg_addr (reg_addr),
		.i_reg_data (reg_data),
		.i_rd_ch    (rd_ch),
		.o_fnum     (fnum),
		.o_block    (block),
		.o_key      (key),
		.o_atten    (atten)
	);

	opll_tone_gen u_tone_gen (
		.clk           (clk),
		.n_reset       (n_reset),
		.i_mclk_pcen_n (i_mclk_pcen_n),
		.i_fnum        (fnum),
		.i_block       (block),
		.i_key         (key),
		.i_atten       (atten),
		.o_rd_ch       (rd_ch),
		.o_smp_valid   (smp_valid),
		.o_smp_ch      (smp_ch),
		.o_smp_val     (smp_val)
	);

	opll_mixer u_mixer (
		.clk          (clk),
		.n_reset      (n_reset),
		.i_smp_valid  (smp_valid),
		.i_smp_ch     (smp_ch),
		.i_smp_val    (smp_val),
		.o_sound_strb (o_sound_strb),
		.o_sound_out  (o_sound_out)
	);

endmodule

/* tb_opll_top.sv */
/*
 * OPLL sound subsystem testbench
 * bus writes over memory and I/O ports, frame model of the tone and mixer
 * rules, and a compare process on every sound strobe
 */
`timescale 1ns/1ns
`include "opll_cfg.svh"

module tb_opll_top;
	import opll_pkg::*;

	localparam int CH_NUM  = `OPLL_CH_NUM;
	localparam int PW      = `OPLL_PHASE_W;
	localparam int TIMEOUT = 200;       // clocks per strobe wait

	logic        clk;
	logic        n_reset;
	logic        i_mclk_pcen_n;
	logic        i_n_ioreq;
	logic        i_n_sltsl;
	logic        i_n_wr;
	logic [15:0] i_address;
	logic [7:0]  i_wdata;
	logic        o_sound_strb;
	logic [15:0] o_sound_out;

	integer seed;
	int     errors;
	int     checks;
	int     strb_cnt;
	logic [15:0] exp_q [$];             // expected words in frame order

	// ------------------------------
	// reference state
	// ------------------------------
	logic [7:0]     m_addr;             // last latched register address
	logic           m_io_en;
	logic [7:0]     m_fnum_lo [CH_NUM];
	opll_reg_data_u m_ctrl    [CH_NUM];
	opll_reg_data_u m_patch   [CH_NUM];
	int             m_phase   [CH_NUM];

	opll_top #(
		.BUILT_IN_MODE (0)
	) u_opll_top (
		.clk           (clk),
		.n_reset       (n_reset),
		.i_mclk_pcen_n (i_mclk_pcen_n),
		.i_n_ioreq     (i_n_ioreq),
		.i_n_sltsl     (i_n_sltsl),
		.i_n_wr        (i_n_wr),
		.i_address     (i_address),
		.i_wdata       (i_wdata),
		.o_sound_strb  (o_sound_strb),
		.o_sound_out   (o_sound_out)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;         // 100 ns period
	end

	task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	function automatic opll_reg_data_u ctrl_byte(input logic key, input logic [2:0] block,
	                                             input logic fnum_hi);
		opll_reg_data_u u;
		u.ctrl.rsvd    = 2'b00;
		u.ctrl.sus     = 1'b0;
		u.ctrl.key     = key;
		u.ctrl.block   = block;
		u.ctrl.fnum_hi = fnum_hi;
		return u;
	endfunction

	function automatic opll_reg_data_u patch_byte(input logic [3:0] inst, input logic [3:0] atten);
		opll_reg_data_u u;
		u.patch.inst  = inst;
		u.patch.atten = atten;
		return u;
	endfunction

	// data byte into the latched register of the three groups
	function automatic void model_data(input logic [7:0] d);
		if (m_addr >= 8'h10 && m_addr <= 8'h18) m_fnum_lo[m_addr - 8'h10] = d;
		if (m_addr >= 8'h20 && m_addr <= 8'h28) m_ctrl[m_addr - 8'h20] = d;
		if (m_addr >= 8'h30 && m_addr <= 8'h38) m_patch[m_addr - 8'h30] = d;
	endfunction

	// one reference frame that advances the phases
	function automatic logic [15:0] ref_frame();
		int sum;
		int inc;
		int amp;
		int scaled;
		sum = 0;
		for (int ch = 0; ch < CH_NUM; ch++) begin
			inc = {m_ctrl[ch].ctrl.fnum_hi, m_fnum_lo[ch]} << m_ctrl[ch].ctrl.block;
			if (m_ctrl[ch].ctrl.key) begin
				m_phase[ch] = (m_phase[ch] + inc) % (1 << PW);
				amp = (15 - m_patch[ch].patch.atten) * 64;
			end else begin
				m_phase[ch] = 0;                // key-off restarts at 0
				amp = 0;
			end
			sum += ((m_phase[ch] >> (PW - 1)) & 1) ? -amp : amp;
		end
		scaled = sum * (1 << `OPLL_MIX_SHIFT);
		if (scaled > 32767) scaled = 32767;
		if (scaled < -32768) scaled = -32768;
		return scaled[15:0];
	endfunction

	// ------------------------------
	// bus writes
	// ------------------------------
	task mem_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		i_address <= addr;
		i_wdata   <= data;
		i_n_sltsl <= 1'b0;
		i_n_wr    <= 1'b0;
		repeat (2) @(posedge clk);      // write held two clocks
		i_n_sltsl <= 1'b1;
		i_n_wr    <= 1'b1;
		@(posedge clk);
		if (addr == `OPLL_MEM_ADDR) m_addr = data;
		if (addr == `OPLL_MEM_ADDR + 16'd1) model_data(data);
		if (addr == `OPLL_IOEN_ADDR) m_io_en = data[0];
	endtask

	task io_write(input logic [7:0] port, input logic [7:0] data);
		@(posedge clk);
		i_address <= {8'h00, port};
		i_wdata   <= data;
		i_n_ioreq <= 1'b0;
		i_n_wr    <= 1'b0;
		repeat (2) @(posedge clk);
		i_n_ioreq <= 1'b1;
		i_n_wr    <= 1'b1;
		@(posedge clk);
		if (m_io_en && port == `OPLL_IO_ADDR) m_addr = data;
		if (m_io_en && port == `OPLL_IO_ADDR + 8'd1) model_data(data);
	endtask

	task reg_write_mem(input logic [7:0] reg_addr, input logic [7:0] data);
		mem_write(`OPLL_MEM_ADDR, reg_addr);
		mem_write(`OPLL_MEM_ADDR + 16'd1, data);
	endtask

	task reg_write_io(input logic [7:0] reg_addr, input logic [7:0] data);
		io_write(`OPLL_IO_ADDR, reg_addr);
		io_write(`OPLL_IO_ADDR + 8'd1, data);
	endtask

	task wait_strobes(input int target);
		int t;
		t = 0;
		while (strb_cnt < target && t < TIMEOUT) begin
			@(posedge clk);
			t++;
		end
		if (strb_cnt < target) begin
			$display("timeout, sound strobe count stuck at %0d of %0d", strb_cnt, target);
			$display("TEST FAILED");
			$finish;
		end
	endtask

	// exactly nine enabled clocks per frame
	task run_frames(input int n);
		int target;
		for (int f = 0; f < n; f++) begin
			exp_q.push_back(ref_frame());
		end
		target = strb_cnt + n;
		@(posedge clk);
		i_mclk_pcen_n <= 1'b0;
		repeat (CH_NUM * n) @(posedge clk);
		i_mclk_pcen_n <= 1'b1;
		wait_strobes(target);
	endtask

	// compare process
	always @(posedge clk) begin
		if (n_reset && o_sound_strb) begin
			strb_cnt++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("sound strobe arrived with no frame expected");
			end else begin
				check_value("o_sound_out", o_sound_out, exp_q.pop_front());
			end
		end
	end

	initial begin
		logic [8:0] fnum;
		logic [2:0] block;
		logic [3:0] atten;
		seed     = 82;
		errors   = 0;
		checks   = 0;
		strb_cnt = 0;
		n_reset       = 1'b0;
		i_mclk_pcen_n = 1'b1;
		i_n_ioreq     = 1'b1;
		i_n_sltsl     = 1'b1;
		i_n_wr        = 1'b1;
		i_address     = '0;
		i_wdata       = '0;
		m_addr  = '0;
		m_io_en = 1'b0;                 // cartridge mode
		for (int ch = 0; ch < CH_NUM; ch++) begin
			m_fnum_lo[ch] = '0;
			m_ctrl[ch]    = '0;
			m_patch[ch]   = '0;
			m_phase[ch]   = 0;
		end
		repeat (8) @(posedge clk);
		n_reset <= 1'b1;
		repeat (2) @(posedge clk);

		run_frames(5);                  // silent after reset

		// one channel over the memory ports
		reg_write_mem(8'h13, 8'h55);
		reg_write_mem(8'h33, patch_byte(4'h2, 4'hA));
		reg_write_mem(8'h23, ctrl_byte(1'b1, 3'd6, 1'b1));
		run_frames(40);

		// I/O ports disabled then enabled
		reg_write_io(8'h15, 8'hC3);
		reg_write_io(8'h35, patch_byte(4'h1, 4'h9));
		reg_write_io(8'h25, ctrl_byte(1'b1, 3'd7, 1'b0));
		run_frames(10);
		mem_write(`OPLL_IOEN_ADDR, 8'h01);
		reg_write_io(8'h15, 8'hC3);
		reg_write_io(8'h35, patch_byte(4'h1, 4'h9));
		reg_write_io(8'h25, ctrl_byte(1'b1, 3'd7, 1'b0));
		run_frames(20);

		// random tones on every channel
		for (int ch = 0; ch < CH_NUM; ch++) begin
			fnum  = $random(seed);
			block = $random(seed);
			atten = $random(seed);
			reg_write_mem(8'h10 + ch, fnum[7:0]);
			reg_write_mem(8'h30 + ch, patch_byte(4'h0, atten));
			reg_write_mem(8'h20 + ch, ctrl_byte(1'b1, block, fnum[8]));
		end
		run_frames(20);
		for (int ch = 0; ch < CH_NUM; ch++) begin
			reg_write_mem(8'h30 + ch, patch_byte(4'h0, 4'h0));    // full volume
		end
		run_frames(10);

		// channels 0 and 3 alone, mix stays below clipping
		for (int ch = 0; ch < CH_NUM; ch++) begin
			atten = (ch == 0 || ch == 3) ? 4'hC : 4'hF;
			reg_write_mem(8'h30 + ch, patch_byte(4'h0, atten));
		end

		// key-off then key-on of channel 3
		reg_write_mem(8'h23, ctrl_byte(1'b0, 3'd6, 1'b1));
		run_frames(6);
		reg_write_mem(8'h23, ctrl_byte(1'b1, 3'd6, 1'b1));
		run_frames(10);

		// unused register addresses, 50h and 63h alias ch 0 and ch 3 in 6 bits
		reg_write_mem(8'h09, $random(seed));
		reg_write_mem(8'h19, $random(seed));
		reg_write_mem(8'h29, $random(seed));
		reg_write_mem(8'h3F, $random(seed));
		reg_write_mem(8'h50, $random(seed));
		reg_write_mem(8'h63, $random(seed));
		run_frames(10);

		repeat (4) @(posedge clk);
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d expected frames never got a strobe", exp_q.size());
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+.
opll_pkg.sv
opll_bus_decoder.sv
opll_reg_file.sv
opll_tone_gen.sv
opll_mixer.sv
opll_top.sv
tb_opll_top.sv

/* Bender.yml */
package:
  name: opll_sound

sources:
  - include_dirs:
      - .
    files:
      - opll_pkg.sv
      - opll_bus_decoder.sv
      - opll_reg_file.sv
      - opll_tone_gen.sv
      - opll_mixer.sv
      - opll_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_opll_top.sv
